// File: files.f
+incdir+include
logic/conv_pkg.sv
logic/dual_port_ram.sv
logic/conv_regs.sv
logic/conv_engine.sv
logic/dmem_port_ctrl.sv
logic/conv_accel_top.sv
testbench/conv_accel_tb.sv

// File: include/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// data path word
`define CONV_DATA_W 32

// word address into the data memory
`define CONV_ADDR_W 12

`define CONV_MEM_DEPTH 4096

// kernel edge, rows and columns
`define CONV_WT_DIM 3

// burst length field
`define CONV_LEN_W 4

// apb address bit that opens the memory window
`define CONV_MEM_WIN_BIT 16

`endif

// File: logic/conv_accel_top.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_accel_top import conv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`CONV_MEM_WIN_BIT:0] paddr_i,
    input  word_t                      pwdata_i,
    output word_t                      prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);
    logic   start, soft_rst, idle, done;
    word_t  fm_dim;
    maddr_t wt_off, ifm_off, ofm_off;
    logic   host_en, host_we;
    maddr_t host_addr;
    word_t  host_wdata, host_rdata;
    maddr_t rd_req_addr, wr_req_addr;
    blen_t  rd_req_len, wr_req_len;
    logic   rd_req_valid, rd_req_ready, rd_data_valid, rd_data_ready;
    logic   wr_req_valid, wr_req_ready, wr_data_valid, wr_data_ready;
    logic   wr_status_valid, wr_status_ready;
    word_t  rd_data, wr_data;
    maddr_t a_addr, b_addr;
    word_t  a_rdata, b_wdata;
    logic   b_we;

    conv_regs conv_regs_i (
        .clk(clk), .reset_i(reset_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .idle_i(idle), .done_i(done), .start_o(start), .soft_rst_o(soft_rst),
        .fm_dim_o(fm_dim), .wt_off_o(wt_off), .ifm_off_o(ifm_off), .ofm_off_o(ofm_off),
        .host_en_o(host_en), .host_we_o(host_we), .host_addr_o(host_addr),
        .host_wdata_o(host_wdata), .host_rdata_i(host_rdata)
    );

    conv_engine conv_engine_i (
        .clk(clk), .reset_i(reset_i), .soft_rst_i(soft_rst),
        .start_i(start), .idle_o(idle), .done_o(done),
        .fm_dim_i(fm_dim), .wt_off_i(wt_off), .ifm_off_i(ifm_off), .ofm_off_i(ofm_off),
        .rd_req_addr_o(rd_req_addr), .rd_req_len_o(rd_req_len),         // read request
        .rd_req_valid_o(rd_req_valid), .rd_req_ready_i(rd_req_ready),
        .rd_data_i(rd_data), .rd_data_valid_i(rd_data_valid),            // read response
        .rd_data_ready_o(rd_data_ready),
        .wr_req_addr_o(wr_req_addr), .wr_req_len_o(wr_req_len),         // write request
        .wr_req_valid_o(wr_req_valid), .wr_req_ready_i(wr_req_ready),
        .wr_data_o(wr_data), .wr_data_valid_o(wr_data_valid),            // write data
        .wr_data_ready_i(wr_data_ready),
        .wr_status_valid_i(wr_status_valid), .wr_status_ready_o(wr_status_ready)
    );

    dmem_port_ctrl dmem_port_ctrl_i (
        .clk(clk), .reset_i(reset_i | soft_rst),  // open bursts end with the engine
        .rd_req_addr_i(rd_req_addr), .rd_req_len_i(rd_req_len),
        .rd_req_valid_i(rd_req_valid), .rd_req_ready_o(rd_req_ready),
        .rd_data_o(rd_data), .rd_data_valid_o(rd_data_valid),
        .rd_data_ready_i(rd_data_ready),
        .wr_req_addr_i(wr_req_addr), .wr_req_len_i(wr_req_len),
        .wr_req_valid_i(wr_req_valid), .wr_req_ready_o(wr_req_ready),
        .wr_data_i(wr_data), .wr_data_valid_i(wr_data_valid),
        .wr_data_ready_o(wr_data_ready),
        .wr_status_valid_o(wr_status_valid), .wr_status_ready_i(wr_status_ready),
        .host_en_i(host_en), .host_we_i(host_we), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
        .a_addr_o(a_addr), .a_rdata_i(a_rdata),                          // port a reads
        .b_addr_o(b_addr), .b_wdata_o(b_wdata), .b_we_o(b_we)            // port b writes
    );

    dual_port_ram #(
        .DEPTH(`CONV_MEM_DEPTH)
    ) dmem_i (
        .clk(clk),
        .a_addr_i(a_addr), .a_rdata_o(a_rdata),
        .b_addr_i(b_addr), .b_wdata_i(b_wdata), .b_we_i(b_we)
    );

endmodule

// File: logic/conv_engine.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_engine import conv_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   soft_rst_i,
    input  logic   start_i,
    output logic   idle_o,
    output logic   done_o,
    input  word_t  fm_dim_i,
    input  maddr_t wt_off_i,
    input  maddr_t ifm_off_i,
    input  maddr_t ofm_off_i,
    output maddr_t rd_req_addr_o,
    output blen_t  rd_req_len_o,
    output logic   rd_req_valid_o,
    input  logic   rd_req_ready_i,
    input  word_t  rd_data_i,
    input  logic   rd_data_valid_i,
    output logic   rd_data_ready_o,
    output maddr_t wr_req_addr_o,
    output blen_t  wr_req_len_o,
    output logic   wr_req_valid_o,
    input  logic   wr_req_ready_i,
    output word_t  wr_data_o,
    output logic   wr_data_valid_o,
    input  logic   wr_data_ready_i,
    input  logic   wr_status_valid_i,
    output logic   wr_status_ready_o
);
    localparam int KN = `CONV_WT_DIM * `CONV_WT_DIM;

    typedef enum logic [2:0] {
        S_IDLE, S_WT_REQ, S_WT_DATA, S_ROW_REQ, S_ROW_DATA, S_WR_REQ, S_WR_DATA, S_WR_RESP
    } state_e;

    state_e     state_q;
    logic       done_q;
    logic [1:0] ky_q;
    logic [3:0] wi_q;
    blen_t      beats_q;
    maddr_t     x_q;
    maddr_t     y_q;
    maddr_t     pos_q;
    word_t      acc_q;
    word_t      wt_q [KN];
    maddr_t     dim;
    maddr_t     last;
    maddr_t     row_addr;
    logic       row_ok;
    logic       x_first;
    logic       x_last;
    logic       last_row;
    logic       rd_beat;
    logic       last_beat;
    blen_t      row_len;

    assign dim       = fm_dim_i[`CONV_ADDR_W-1:0];
    assign last      = dim - 1'b1;
    assign x_first   = (x_q == '0);
    assign x_last    = (x_q == last);
    assign last_row  = (ky_q == 2'(`CONV_WT_DIM - 1));
    assign rd_beat   = rd_data_valid_i & rd_data_ready_o;
    assign last_beat = rd_beat & (beats_q == blen_t'(1));
    assign row_len   = blen_t'(`CONV_WT_DIM) - blen_t'(x_first) - blen_t'(x_last);  // clip edges

    // kernel row ky covers input row y+ky-1, columns x-1..x+1 clipped to the map
    always_comb begin
        row_ok   = 1'b1;
        row_addr = ifm_off_i + pos_q - maddr_t'(!x_first);
        if (ky_q == 2'd0) begin
            row_ok   = (y_q != '0);  // row above
            row_addr = row_addr - dim;
        end else if (ky_q == 2'd2) begin
            row_ok   = (y_q != last);  // row below
            row_addr = row_addr + dim;
        end
    end

    assign idle_o          = (state_q == S_IDLE);
    assign done_o          = done_q;
    assign rd_req_valid_o  = (state_q == S_WT_REQ) | ((state_q == S_ROW_REQ) & row_ok);
    assign rd_req_addr_o   = (state_q == S_WT_REQ) ?
                             wt_off_i + maddr_t'(ky_q) * maddr_t'(`CONV_WT_DIM) : row_addr;
    assign rd_req_len_o    = (state_q == S_WT_REQ) ? blen_t'(`CONV_WT_DIM) : row_len;
    assign rd_data_ready_o = (state_q == S_WT_DATA) | (state_q == S_ROW_DATA);
    assign wr_req_valid_o  = (state_q == S_WR_REQ);
    assign wr_req_addr_o   = ofm_off_i + pos_q;
    assign wr_req_len_o    = blen_t'(1);  // one output word per burst
    assign wr_data_valid_o = (state_q == S_WR_DATA);
    assign wr_data_o       = acc_q;
    assign wr_status_ready_o = (state_q == S_WR_RESP);

    always_ff @(posedge clk) begin
        if ((state_q == S_WT_DATA) && rd_beat) begin
            wt_q[wi_q] <= rd_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i | soft_rst_i) begin
            state_q <= S_IDLE;
            done_q  <= 1'b0;
            ky_q    <= '0;
            wi_q    <= '0;
            beats_q <= '0;
            x_q     <= '0;
            y_q     <= '0;
            pos_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (start_i) begin
                    state_q <= S_WT_REQ;
                    done_q  <= 1'b0;
                    ky_q    <= '0;
                    wi_q    <= '0;
                    x_q     <= '0;
                    y_q     <= '0;
                    pos_q   <= '0;
                    acc_q   <= '0;
                end
                S_WT_REQ: if (rd_req_ready_i) begin
                    beats_q <= blen_t'(`CONV_WT_DIM);
                    state_q <= S_WT_DATA;
                end
                S_WT_DATA: begin
                    if (rd_beat) begin
                        wi_q    <= wi_q + 1'b1;
                        beats_q <= beats_q - 1'b1;
                    end
                    if (last_beat) begin
                        ky_q    <= last_row ? 2'd0 : ky_q + 1'b1;
                        state_q <= last_row ? S_ROW_REQ : S_WT_REQ;
                    end
                end
                S_ROW_REQ: if (!row_ok) begin  // row lies in the zero padding
                    ky_q    <= last_row ? 2'd0 : ky_q + 1'b1;
                    state_q <= last_row ? S_WR_REQ : S_ROW_REQ;
                end else if (rd_req_ready_i) begin
                    beats_q <= row_len;
                    wi_q    <= 4'(ky_q) * 4'(`CONV_WT_DIM) + 4'(x_first);
                    state_q <= S_ROW_DATA;
                end
                S_ROW_DATA: begin
                    if (rd_beat) begin
                        acc_q   <= acc_q + wt_q[wi_q] * rd_data_i;  // wraps at 32 bits
                        wi_q    <= wi_q + 1'b1;
                        beats_q <= beats_q - 1'b1;
                    end
                    if (last_beat) begin
                        ky_q    <= last_row ? 2'd0 : ky_q + 1'b1;
                        state_q <= last_row ? S_WR_REQ : S_ROW_REQ;
                    end
                end
                S_WR_REQ: if (wr_req_ready_i) begin
                    state_q <= S_WR_DATA;
                end
                S_WR_DATA: if (wr_data_ready_i) begin
                    state_q <= S_WR_RESP;
                end
                S_WR_RESP: if (wr_status_valid_i) begin
                    acc_q <= '0;
                    pos_q <= pos_q + 1'b1;
                    x_q   <= x_last ? '0 : x_q + 1'b1;
                    if (x_last) begin
                        y_q <= y_q + 1'b1;
                    end
                    if (x_last && (y_q == last)) begin
                        state_q <= S_IDLE;  // map finished
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= S_ROW_REQ;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

`include "conv_consts.svh"

    typedef logic [`CONV_DATA_W-1:0] word_t;
    typedef logic [`CONV_ADDR_W-1:0] maddr_t;
    typedef logic [`CONV_LEN_W-1:0]  blen_t;

    // register index, apb address bits 4:2
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,  // 0x00, start and soft reset
        REG_STATUS  = 3'd1,  // 0x04, idle and done
        REG_FM_DIM  = 3'd2,  // 0x08
        REG_WT_OFF  = 3'd3,  // 0x0c
        REG_IFM_OFF = 3'd4,  // 0x10
        REG_OFM_OFF = 3'd5   // 0x14
    } conv_reg_e;

endpackage

// File: logic/conv_regs.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_regs import conv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`CONV_MEM_WIN_BIT:0] paddr_i,
    input  word_t                      pwdata_i,
    output word_t                      prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  logic                       idle_i,
    input  logic                       done_i,
    output logic                       start_o,
    output logic                       soft_rst_o,
    output word_t                      fm_dim_o,
    output maddr_t                     wt_off_o,
    output maddr_t                     ifm_off_o,
    output maddr_t                     ofm_off_o,
    output logic                       host_en_o,
    output logic                       host_we_o,
    output maddr_t                     host_addr_o,
    output word_t                      host_wdata_o,
    input  word_t                      host_rdata_i
);
    logic      access;
    logic      win_sel;
    logic      reg_sel;
    logic      reg_wr;
    logic      ctrl_wr;
    logic      rd_wait_q;
    conv_reg_e reg_idx;
    word_t     fm_dim_q;
    word_t     wt_off_q;
    word_t     ifm_off_q;
    word_t     ofm_off_q;

    assign access  = psel_i & penable_i;
    assign win_sel = paddr_i[`CONV_MEM_WIN_BIT];
    assign reg_sel = ~win_sel & (paddr_i[`CONV_MEM_WIN_BIT-1:5] == '0);
    assign reg_idx = conv_reg_e'(paddr_i[4:2]);
    assign reg_wr  = access & pwrite_i & reg_sel;
    assign ctrl_wr = reg_wr & (reg_idx == REG_CTRL);

    // window read spends its first access cycle on the ram
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= access & win_sel & ~pwrite_i & idle_i & ~rd_wait_q;
        end
    end

    assign pready_o  = access & (~win_sel | pwrite_i | ~idle_i | rd_wait_q);
    assign pslverr_o = access & win_sel & ~idle_i;  // memory belongs to the engine

    assign host_en_o    = access & win_sel & idle_i & ~rd_wait_q;
    assign host_we_o    = pwrite_i;
    assign host_addr_o  = paddr_i[`CONV_ADDR_W+1:2];  // byte to word address
    assign host_wdata_o = pwdata_i;

    assign start_o    = ctrl_wr & pwdata_i[0];
    assign soft_rst_o = ctrl_wr & pwdata_i[1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fm_dim_q  <= '0;
            wt_off_q  <= '0;
            ifm_off_q <= '0;
            ofm_off_q <= '0;
        end else if (reg_wr) begin
            case (reg_idx)
                REG_FM_DIM:  fm_dim_q  <= pwdata_i;
                REG_WT_OFF:  wt_off_q  <= pwdata_i;
                REG_IFM_OFF: ifm_off_q <= pwdata_i;
                REG_OFM_OFF: ofm_off_q <= pwdata_i;
                default:     ;  // ctrl acts as a pulse, status is read only
            endcase
        end
    end

    assign fm_dim_o  = fm_dim_q;
    assign wt_off_o  = wt_off_q[`CONV_ADDR_W-1:0];
    assign ifm_off_o = ifm_off_q[`CONV_ADDR_W-1:0];
    assign ofm_off_o = ofm_off_q[`CONV_ADDR_W-1:0];

    always_comb begin
        prdata_o = '0;
        if (win_sel) begin
            prdata_o = host_rdata_i;
        end else if (reg_sel) begin
            case (reg_idx)
                REG_STATUS:  prdata_o = word_t'({done_i, idle_i});
                REG_FM_DIM:  prdata_o = fm_dim_q;
                REG_WT_OFF:  prdata_o = wt_off_q;
                REG_IFM_OFF: prdata_o = ifm_off_q;
                REG_OFM_OFF: prdata_o = ofm_off_q;
                default:     prdata_o = '0;
            endcase
        end
    end

endmodule

// File: logic/dmem_port_ctrl.sv
`timescale 1ns/10ps

module dmem_port_ctrl import conv_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  maddr_t rd_req_addr_i,
    input  blen_t  rd_req_len_i,
    input  logic   rd_req_valid_i,
    output logic   rd_req_ready_o,
    output word_t  rd_data_o,
    output logic   rd_data_valid_o,
    input  logic   rd_data_ready_i,
    input  maddr_t wr_req_addr_i,
    input  blen_t  wr_req_len_i,
    input  logic   wr_req_valid_i,
    output logic   wr_req_ready_o,
    input  word_t  wr_data_i,
    input  logic   wr_data_valid_i,
    output logic   wr_data_ready_o,
    output logic   wr_status_valid_o,
    input  logic   wr_status_ready_i,
    input  logic   host_en_i,
    input  logic   host_we_i,
    input  maddr_t host_addr_i,
    input  word_t  host_wdata_i,
    output word_t  host_rdata_o,
    output maddr_t a_addr_o,
    input  word_t  a_rdata_i,
    output maddr_t b_addr_o,
    output word_t  b_wdata_o,
    output logic   b_we_o
);
    logic   rd_accept;
    logic   rd_issue;
    logic   rd_stall;
    logic   rd_beat;
    logic   wr_beat;
    logic   host_rd;
    logic   host_wr;
    maddr_t rd_addr_q;
    maddr_t wr_addr_q;
    blen_t  rd_issue_q;
    blen_t  rd_beat_q;
    blen_t  wr_left_q;
    logic   pend_q;
    logic   hold_v_q;
    logic   wr_stat_q;
    word_t  hold_q;

    assign host_rd = host_en_i & ~host_we_i;
    assign host_wr = host_en_i & host_we_i;
    assign host_rdata_o = a_rdata_i;

    assign rd_req_ready_o  = (rd_beat_q == '0);  // previous burst fully handed off
    assign rd_accept       = rd_req_valid_i & rd_req_ready_o;
    assign rd_data_valid_o = pend_q | hold_v_q;
    assign rd_data_o       = hold_v_q ? hold_q : a_rdata_i;
    assign rd_stall        = rd_data_valid_o & ~rd_data_ready_i;
    assign rd_issue        = (rd_issue_q != '0) & ~rd_stall;  // address pauses under stall
    assign rd_beat         = rd_data_valid_o & rd_data_ready_i;
    assign a_addr_o = host_rd ? host_addr_i : (rd_accept ? rd_req_addr_i : rd_addr_q);

    assign wr_req_ready_o    = (wr_left_q == '0) & ~wr_stat_q;
    assign wr_data_ready_o   = (wr_left_q != '0);
    assign wr_beat           = wr_data_valid_i & wr_data_ready_o;
    assign wr_status_valid_o = wr_stat_q;
    assign b_we_o    = host_wr | wr_beat;
    assign b_addr_o  = host_wr ? host_addr_i : wr_addr_q;
    assign b_wdata_o = host_wr ? host_wdata_i : wr_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_issue_q <= '0;
            rd_beat_q  <= '0;
            pend_q     <= 1'b0;
            hold_v_q   <= 1'b0;
            wr_left_q  <= '0;
            wr_stat_q  <= 1'b0;
        end else begin
            pend_q <= rd_accept | rd_issue;  // ram word lands next cycle
            if (rd_accept) begin
                rd_addr_q  <= rd_req_addr_i + 1'b1;
                rd_issue_q <= rd_req_len_i - 1'b1;
                rd_beat_q  <= rd_req_len_i;
            end else begin
                if (rd_issue) begin
                    rd_addr_q  <= rd_addr_q + 1'b1;
                    rd_issue_q <= rd_issue_q - 1'b1;
                end
                if (rd_beat) begin
                    rd_beat_q <= rd_beat_q - 1'b1;
                end
            end
            if (pend_q & rd_stall & ~hold_v_q) begin
                hold_v_q <= 1'b1;  // park the word the ram just returned
                hold_q   <= a_rdata_i;
            end else if (hold_v_q & rd_data_ready_i) begin
                hold_v_q <= 1'b0;
            end
            if (wr_req_valid_i & wr_req_ready_o) begin
                wr_addr_q <= wr_req_addr_i;
                wr_left_q <= wr_req_len_i;
            end else if (wr_beat) begin
                wr_addr_q <= wr_addr_q + 1'b1;
                wr_left_q <= wr_left_q - 1'b1;
            end
            if (wr_beat && (wr_left_q == blen_t'(1))) begin
                wr_stat_q <= 1'b1;
            end else if (wr_status_ready_i) begin
                wr_stat_q <= 1'b0;
            end
        end
    end

endmodule

// File: logic/dual_port_ram.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module dual_port_ram import conv_pkg::*; #(
    parameter int DEPTH = `CONV_MEM_DEPTH
) (
    input  logic   clk,
    input  maddr_t a_addr_i,
    output word_t  a_rdata_o,
    input  maddr_t b_addr_i,
    input  word_t  b_wdata_i,
    input  logic   b_we_i
);
    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        a_rdata_o <= mem[a_addr_i];  // one cycle read latency
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench and RTL with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
    --top-module conv_accel_tb -f files.f -o conv_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/conv_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Regression passed'; then
    exit 0
fi
exit 1

// File: testbench/conv_accel_tb.sv
`timescale 1ns/10ps
`include "conv_consts.svh"

module conv_accel_tb import conv_pkg::*; ();
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int WDOG_CYCLES  = 2000;  // per data file line
    localparam int MAX_WAITS    = 8;
    localparam int MAX_POLLS    = 2000;
    localparam logic [`CONV_MEM_WIN_BIT:0] STATUS_ADDR = 17'h00004;

    logic                       clk;
    logic                       reset_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [`CONV_MEM_WIN_BIT:0] paddr_i;
    word_t                      pwdata_i;
    word_t                      prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;

    logic [7:0]                 cmd_q [$];
    logic [`CONV_MEM_WIN_BIT:0] addr_q [$];
    word_t                      val_q [$];
    logic                       load_done;
    int                         n_fail;
    int                         n_bad;

    conv_accel_top conv_accel_top_i (
        .clk(clk), .reset_i(reset_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each line holds a command letter, an apb byte address and a value
    // lines starting with # are notes
    task automatic load_tests(output int n);
        int                         fd;
        int                         cnt;
        string                      line;
        logic [7:0]                 cmd;
        logic [`CONV_MEM_WIN_BIT:0] addr;
        word_t                      val;
        n = 0;
        fd = $fopen("testbench/conv_tests.dat", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%s %h %h", cmd, addr, val);
                if (cnt == 3) begin
                    cmd_q.push_back(cmd);
                    addr_q.push_back(addr);
                    val_q.push_back(val);
                end
            end
        end
        $fclose(fd);
        n = cmd_q.size();
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("MISMATCH at %0d ns: %s expected %08h, got %08h", $time, name, exp, act);
            n_fail++;
        end
    endtask

    // one apb transfer through setup and access until pready
    task automatic apb_xfer(input logic wr, input logic [`CONV_MEM_WIN_BIT:0] addr,
                            input word_t wdata, output word_t rdata, output logic err,
                            output int waits);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        waits = 0;
        #1;  // sample in the low phase before the completing edge
        while (!pready_o && waits < MAX_WAITS) begin
            @(negedge clk);
            #1;
            waits++;
        end
        assert (pready_o) else begin
            $display("APB transfer to %05h saw no pready_o within %0d wait states",
                     addr, MAX_WAITS);
            n_fail++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic run_test(input int idx);
        logic [7:0]                 cmd;
        logic [`CONV_MEM_WIN_BIT:0] addr;
        word_t                      val;
        word_t                      rdata;
        logic                       err;
        int                         waits;
        int                         exp_waits;
        int                         fails_before;
        int                         polls;
        cmd          = cmd_q[idx];
        addr         = addr_q[idx];
        val          = val_q[idx];
        fails_before = n_fail;
        repeat ($urandom_range(3, 0)) @(negedge clk);  // random idle gap
        case (cmd)
            "W": begin
                apb_xfer(1'b1, addr, val, rdata, err, waits);
                check_value("pslverr_o", '0, word_t'(err));
                check_value("pready_o wait states", '0, word_t'(waits));
            end
            "R": begin
                exp_waits = addr[`CONV_MEM_WIN_BIT] ? 1 : 0;  // ram read takes one wait
                apb_xfer(1'b0, addr, '0, rdata, err, waits);
                check_value("pslverr_o", '0, word_t'(err));
                check_value("pready_o wait states", word_t'(exp_waits), word_t'(waits));
                check_value("prdata_o", val, rdata);
            end
            "E": begin
                apb_xfer(1'b0, addr, '0, rdata, err, waits);
                check_value("pslverr_o", 32'd1, word_t'(err));
                check_value("pready_o wait states", '0, word_t'(waits));
            end
            "G": begin
                apb_xfer(1'b1, addr, val, rdata, err, waits);  // start bit
                check_value("pslverr_o", '0, word_t'(err));
                check_value("pready_o wait states", '0, word_t'(waits));
                polls = 0;
                rdata = '0;
                while (!rdata[1] && polls < MAX_POLLS) begin
                    apb_xfer(1'b0, STATUS_ADDR, '0, rdata, err, waits);
                    polls++;
                end
                assert (rdata[1]) else begin
                    $display("engine did not report done after %0d status polls", polls);
                    n_fail++;
                end
            end
            default: begin
                $display("unknown command '%s' in test %0d", cmd, idx + 1);
                n_fail++;
            end
        endcase
        if (n_fail != fails_before) begin
            n_bad++;
        end
        $display("test %0d: %s %05h %08h %s", idx + 1, cmd, addr, val,
                 (n_fail == fails_before) ? "ok" : "FAILED");
    endtask

    initial begin : main
        int n_tests;
        int i;
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        n_fail    = 0;
        n_bad     = 0;
        load_done = 1'b0;
        void'($urandom(32'h7e68));
        load_tests(n_tests);
        if (n_tests == 0) begin
            $display("no test commands could be read from testbench/conv_tests.dat");
            n_fail++;
        end
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        for (i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d failed, %0d failed checks", n_tests, n_bad, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (load_done);
        repeat ((cmd_q.size() + 1) * WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the tests did not finish in %0d cycles",
                 (cmd_q.size() + 1) * WDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: testbench/conv_tests.dat
# cmd addr value: W write, R read and compare, E read expecting pslverr, G start and wait
# addresses are apb bytes, memory window at 10000 plus 4 per word, all values hex
R 00004 00000001
W 00004 00000003
R 00004 00000001
R 00000 00000000
R 00040 00000000
W 00008 00000004
W 0000C A5A50000
W 00010 00000010
W 00014 00000020
R 00008 00000004
R 0000C A5A50000
R 00010 00000010
R 00014 00000020
# kernel 1..9 at word 0, input map 1..16 at word 16
W 10000 00000001
W 10004 00000002
W 10008 00000003
W 1000C 00000004
W 10010 00000005
W 10014 00000006
W 10018 00000007
W 1001C 00000008
W 10020 00000009
W 10040 00000001
W 10044 00000002
W 10048 00000003
W 1004C 00000004
W 10050 00000005
W 10054 00000006
W 10058 00000007
W 1005C 00000008
W 10060 00000009
W 10064 0000000A
W 10068 0000000B
W 1006C 0000000C
W 10070 0000000D
W 10074 0000000E
W 10078 0000000F
W 1007C 00000010
R 10000 00000001
R 10020 00000009
R 10040 00000001
R 1007C 00000010
G 00000 00000001
R 00004 00000003
R 10080 0000006F
R 10084 000000B2
R 10088 000000D9
R 1008C 00000091
R 10090 000000E7
R 10094 0000015C
R 10098 00000189
R 1009C 000000FC
R 100A0 0000016B
R 100A4 00000210
R 100A8 0000023D
R 100AC 00000168
R 100B0 000000C5
R 100B4 00000112
R 100B8 00000127
R 100BC 000000AF
# second run, kernel -1..-9, output map at word 48
W 00014 00000030
W 10000 FFFFFFFF
W 10004 FFFFFFFE
W 10008 FFFFFFFD
W 1000C FFFFFFFC
W 10010 FFFFFFFB
W 10014 FFFFFFFA
W 10018 FFFFFFF9
W 1001C FFFFFFF8
W 10020 FFFFFFF7
G 00000 00000001
R 00004 00000003
R 100C0 FFFFFF91
R 100C4 FFFFFF4E
R 100C8 FFFFFF27
R 100CC FFFFFF6F
R 100D0 FFFFFF19
R 100D4 FFFFFEA4
R 100D8 FFFFFE77
R 100DC FFFFFF04
R 100E0 FFFFFE95
R 100E4 FFFFFDF0
R 100E8 FFFFFDC3
R 100EC FFFFFE98
R 100F0 FFFFFF3B
R 100F4 FFFFFEEE
R 100F8 FFFFFED9
R 100FC FFFFFF51
# window access while busy, then a soft reset mid run
W 00000 00000001
R 00004 00000000
E 10040 00000000
E 100C0 00000000
G 00000 00000001
R 10040 00000001
R 100C0 FFFFFF91
W 00000 00000001
W 00000 00000002
R 00004 00000001
